// File: Makefile
TOP = tb_nts_extractor

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f nts_extractor.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f nts_extractor.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: nts_engine_reader.sv
// Engine reader that drains one packet at a time from the engine FIFO into a slot
`timescale 1ns/1ps

module nts_engine_reader (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  input  logic                                 i_engine_packet_available,
  input  logic                                 i_engine_fifo_empty,
  input  logic [nts_extractor_pkg::DATA_W-1:0] i_engine_fifo_rd_data,
  input  nts_extractor_pkg::lwdv_t             i_engine_bytes_last_word,
  output logic                                 o_engine_fifo_rd_en,
  output logic                                 o_engine_packet_read,

  nts_wr_if.master                             wr
);

  // ----------------------------------------
  // State
  // ----------------------------------------

  // Low while idle, high while a packet is being copied
  logic writing;
  // Registered end-of-packet pulse, doubles as the buffer commit
  logic packet_read;
  // FIFO ran dry during a copy
  logic packet_done;
  logic claim;

  // ----------------------------------------
  // Control decode
  // ----------------------------------------

  // A new packet is only claimed when the engine has a full one and a slot is free
  assign claim = !writing && i_engine_packet_available && !i_engine_fifo_empty && wr.free;

  // First empty cycle while writing closes the packet
  assign packet_done = writing && i_engine_fifo_empty;

  // ----------------------------------------
  // Buffer side
  // ----------------------------------------

  assign wr.start  = claim;
  // Byte count is only taken by the buffer on start
  assign wr.lwdv   = i_engine_bytes_last_word;

  // FWFT FIFO, the head word is stored in the cycle it is popped
  assign wr.we     = writing && !i_engine_fifo_empty;
  assign wr.wdata  = i_engine_fifo_rd_data;
  assign wr.commit = packet_read;

  // ----------------------------------------
  // Engine side
  // ----------------------------------------

  assign o_engine_fifo_rd_en  = wr.we;
  assign o_engine_packet_read = packet_read;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      writing     <= 1'b0;
      packet_read <= 1'b0;
    end else begin
      packet_read <= packet_done;
      if (claim) begin
        writing <= 1'b1;
      end else if (packet_done) begin
        writing <= 1'b0;
      end
    end
  end

endmodule

// File: nts_extractor.f
nts_extractor_pkg.sv
nts_extractor_if.sv
nts_engine_reader.sv
nts_packet_buffer.sv
nts_mac_tx.sv
nts_extractor.sv
nts_extractor_assertions.sv
tb_nts_extractor.sv

// File: nts_extractor.sv
// Packet extractor top level joining engine reader, packet buffer and MAC transmitter
`timescale 1ns/1ps

module nts_extractor (
  input  logic                                         i_clk,
  input  logic                                         i_areset,

  // Packet engine FIFO
  input  logic                                         i_engine_packet_available,
  output logic                                         o_engine_packet_read,
  input  logic                                         i_engine_fifo_empty,
  output logic                                         o_engine_fifo_rd_en,
  input  logic [nts_extractor_pkg::DATA_W-1:0]         i_engine_fifo_rd_data,
  input  nts_extractor_pkg::lwdv_t                     i_engine_bytes_last_word,

  // Ethernet MAC transmitter
  output logic                                         o_mac_tx_start,
  input  logic                                         i_mac_tx_ack,
  output logic [nts_extractor_pkg::BYTES_PER_WORD-1:0] o_mac_tx_data_valid,
  output logic [nts_extractor_pkg::DATA_W-1:0]         o_mac_tx_data
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------

  nts_wr_if wr_bus ();
  nts_rd_if rd_bus ();

  // ----------------------------------------
  // Blocks
  // ----------------------------------------

  nts_engine_reader reader_i (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .wr                        (wr_bus.master)
  );

  nts_packet_buffer buffer_i (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .wr       (wr_bus.slave),
    .rd       (rd_bus.slave)
  );

  nts_mac_tx mac_tx_i (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data),
    .rd                  (rd_bus.master)
  );

endmodule

// File: nts_extractor_assertions.sv
// Port protocol checks bound to the packet extractor top level
`timescale 1ns/1ps

module nts_extractor_assertions (
  input logic       i_clk,
  input logic       i_areset,
  input logic       i_engine_fifo_empty,
  input logic       o_engine_fifo_rd_en,
  input logic       o_engine_packet_read,
  input logic [3:0] i_engine_bytes_last_word,
  input logic       o_mac_tx_start,
  input logic [7:0] o_mac_tx_data_valid
);

  // ----------------------------------------
  // Pulses
  // ----------------------------------------

  start_one_cycle: assert property (@(posedge i_clk) disable iff (i_areset)
    o_mac_tx_start |=> !o_mac_tx_start)
    else $error("MAC start pulse longer than one cycle");

  packet_read_one_cycle: assert property (@(posedge i_clk) disable iff (i_areset)
    o_engine_packet_read |=> !o_engine_packet_read)
    else $error("Packet read pulse longer than one cycle");

  // ----------------------------------------
  // Data and FIFO side
  // ----------------------------------------

  // Mask plus one clears every set bit only when the mask is contiguous from bit 0
  mask_contiguous: assert property (@(posedge i_clk) disable iff (i_areset)
    (o_mac_tx_data_valid & (o_mac_tx_data_valid + 8'd1)) == 8'd0)
    else $error("Byte-valid mask is not contiguous from bit 0");

  no_read_when_empty: assert property (@(posedge i_clk) disable iff (i_areset)
    o_engine_fifo_rd_en |-> !i_engine_fifo_empty)
    else $error("FIFO read enable while the FIFO is empty");

  // Byte count is taken in the claim cycle, one clock before read enable rises
  byte_count_range: assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_engine_fifo_rd_en) |->
      ($past(i_engine_bytes_last_word) >= 4'd1 && $past(i_engine_bytes_last_word) <= 4'd8))
    else $error("Last-word byte count outside 1 to 8");

endmodule

bind nts_extractor nts_extractor_assertions assertions_i (
  .i_clk                    (i_clk),
  .i_areset                 (i_areset),
  .i_engine_fifo_empty      (i_engine_fifo_empty),
  .o_engine_fifo_rd_en      (o_engine_fifo_rd_en),
  .o_engine_packet_read     (o_engine_packet_read),
  .i_engine_bytes_last_word (i_engine_bytes_last_word),
  .o_mac_tx_start           (o_mac_tx_start),
  .o_mac_tx_data_valid      (o_mac_tx_data_valid)
);

// File: nts_extractor_if.sv
// Write-side and read-side links between the packet buffer and its neighbours
`timescale 1ns/1ps

// ----------------------------------------
// Engine reader to packet buffer
// ----------------------------------------

interface nts_wr_if;
  import nts_extractor_pkg::*;

  // Current write slot is unused
  logic              free;
  // Claim the slot and record the last-word byte count
  logic              start;
  lwdv_t             lwdv;
  // One word per high cycle, address is counted inside the buffer
  logic              we;
  logic [DATA_W-1:0] wdata;
  // Packet complete, slot becomes loaded
  logic              commit;

  modport master (
    input  free,
    output start,
    output lwdv,
    output we,
    output wdata,
    output commit
  );

  modport slave (
    output free,
    input  start,
    input  lwdv,
    input  we,
    input  wdata,
    input  commit
  );

endinterface

// ----------------------------------------
// Packet buffer to MAC transmitter
// ----------------------------------------

interface nts_rd_if;
  import nts_extractor_pkg::*;

  // Current read slot holds a complete packet
  logic              loaded;
  word_count_t       words;
  lwdv_t             lwdv;
  // Mark the slot as being read
  logic              take;
  // Read port, data returns one clock after re
  logic              re;
  waddr_t            raddr;
  logic [DATA_W-1:0] rdata;
  // Slot finished, back to unused and advance the ring
  logic              release_slot;

  modport master (
    input  loaded,
    input  words,
    input  lwdv,
    input  rdata,
    output take,
    output re,
    output raddr,
    output release_slot
  );

  modport slave (
    output loaded,
    output words,
    output lwdv,
    output rdata,
    input  take,
    input  re,
    input  raddr,
    input  release_slot
  );

endinterface

// File: nts_extractor_pkg.sv
// Packet extractor shared sizes, slot and transmit state encodings, index types
package nts_extractor_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Packet word and byte lane layout
  localparam int DATA_W         = 64;
  localparam int BYTES_PER_WORD = 8;

  // Ring of packet slots in the buffer RAM
  localparam int NUM_BUFFERS = 4;
  localparam int SLOT_W      = 2;
  localparam int BUF_WORDS   = 32;
  localparam int WORD_ADDR_W = 5;

  // Full RAM address is slot index on top of word address
  localparam int RAM_ADDR_W = SLOT_W + WORD_ADDR_W;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // One extra bit so a completely full slot (32 words) is representable
  typedef logic [WORD_ADDR_W:0]   word_count_t;
  typedef logic [3:0]             lwdv_t;
  typedef logic [SLOT_W-1:0]      slot_t;
  typedef logic [WORD_ADDR_W-1:0] waddr_t;

  typedef enum logic [1:0] {
    BUF_UNUSED  = 2'b00,
    BUF_WRITING = 2'b01,
    BUF_LOADED  = 2'b10,
    BUF_READING = 2'b11
  } buf_state_e;

  typedef enum logic [1:0] {
    TX_IDLE       = 2'd0,
    TX_AWAIT_ACK  = 2'd1,
    TX_WRITE      = 2'd2,
    TX_WRITE_LAST = 2'd3
  } tx_state_e;

endpackage

// File: nts_extractor_tests.txt
# P word_count last_word_bytes ack_delay_cycles
# W packet_word_hex, in send order
# E expected_last_mask_hex expected_last_data_hex
P 3 4 200
W 0011223344556677
W 8899aabbccddeeff
W 0123456789abcdef
E 0f 0000000001234567
P 1 1 2
W a1b2c3d4e5f60718
E 01 00000000000000a1
P 2 7 0
W 1111111111111111
W fedcba9876543210
E 7f 00fedcba98765432
P 2 8 5
W 2222222222222222
W 0f1e2d3c4b5a6978
E ff 0f1e2d3c4b5a6978
P 1 2 1
W 5566778899aabbcc
E 03 0000000000005566

// File: nts_mac_tx.sv
// MAC transmitter that streams loaded slots with start, ack and byte-valid beats
`timescale 1ns/1ps

module nts_mac_tx (
  input  logic                                         i_clk,
  input  logic                                         i_areset,

  input  logic                                         i_mac_tx_ack,
  output logic                                         o_mac_tx_start,
  output logic [nts_extractor_pkg::BYTES_PER_WORD-1:0] o_mac_tx_data_valid,
  output logic [nts_extractor_pkg::DATA_W-1:0]         o_mac_tx_data,

  nts_rd_if.master                                     rd
);
  import nts_extractor_pkg::*;

  // ----------------------------------------
  // Declarations
  // ----------------------------------------

  tx_state_e state;
  tx_state_e state_next;

  // Word being fetched from the slot
  waddr_t raddr;
  logic   read_last;

  logic [BYTES_PER_WORD-1:0] valid_next;
  logic [DATA_W-1:0]         data_next;

  // Last beat formatting
  logic [BYTES_PER_WORD-1:0] last_mask;
  logic [DATA_W-1:0]         last_data;
  logic [6:0]                drop_bits;

  // ----------------------------------------
  // Last word alignment
  // ----------------------------------------

  assign read_last = (word_count_t'(raddr) == rd.words - word_count_t'(1));

  // Valid bytes sit at the top of the stored word, move them down to byte 0
  assign drop_bits = {lwdv_t'(BYTES_PER_WORD) - rd.lwdv, 3'b000};
  assign last_data = rd.rdata >> drop_bits;

  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      last_mask[i] = (i < int'(rd.lwdv));
    end
  end

  // ----------------------------------------
  // Transmit FSM
  // ----------------------------------------

  assign rd.raddr = raddr;

  always_comb begin
    state_next      = state;
    rd.take         = 1'b0;
    rd.re           = 1'b0;
    rd.release_slot = 1'b0;
    valid_next      = '0;
    data_next       = '0;
    case (state)
      TX_IDLE: begin
        if (rd.loaded) begin
          rd.take    = 1'b1;
          state_next = TX_AWAIT_ACK;
        end
      end
      TX_AWAIT_ACK: begin
        if (i_mac_tx_ack) begin
          state_next = TX_WRITE;
        end
      end
      TX_WRITE: begin
        rd.re = 1'b1;
        // RAM data lags the address by one clock, nothing to send on word 0
        if (raddr != '0) begin
          valid_next = '1;
          data_next  = rd.rdata;
        end
        if (read_last) begin
          state_next = TX_WRITE_LAST;
        end
      end
      TX_WRITE_LAST: begin
        valid_next      = last_mask;
        data_next       = last_data;
        rd.release_slot = 1'b1;
        state_next      = TX_IDLE;
      end
      default: state_next = TX_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state               <= TX_IDLE;
      raddr               <= '0;
      o_mac_tx_start      <= 1'b0;
      o_mac_tx_data_valid <= '0;
      o_mac_tx_data       <= '0;
    end else begin
      state               <= state_next;
      o_mac_tx_start      <= rd.take;
      o_mac_tx_data_valid <= valid_next;
      o_mac_tx_data       <= data_next;
      if (state == TX_AWAIT_ACK) begin
        raddr <= '0;
      end else if (state == TX_WRITE && !read_last) begin
        raddr <= raddr + 1'b1;
      end
    end
  end

endmodule

// File: nts_packet_buffer.sv
// Packet buffer ring with word RAM and per-slot state, length and byte-count tables
`timescale 1ns/1ps

module nts_packet_buffer (
  input  logic     i_clk,
  input  logic     i_areset,

  nts_wr_if.slave  wr,
  nts_rd_if.slave  rd
);
  import nts_extractor_pkg::*;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // All slots share one RAM, slot index forms the upper address bits
  logic [DATA_W-1:0] ram [NUM_BUFFERS*BUF_WORDS];
  logic [DATA_W-1:0] rdata_q;

  buf_state_e  slot_state [NUM_BUFFERS];
  word_count_t slot_words [NUM_BUFFERS];
  lwdv_t       slot_lwdv  [NUM_BUFFERS];

  // Ring pointers
  slot_t wr_ptr;
  slot_t rd_ptr;

  // Words written so far into the current write slot
  word_count_t wr_count;
  waddr_t      wr_waddr;

  logic [RAM_ADDR_W-1:0] ram_waddr;
  logic [RAM_ADDR_W-1:0] ram_raddr;

  // ----------------------------------------
  // Addressing and status
  // ----------------------------------------

  assign wr_waddr  = wr_count[WORD_ADDR_W-1:0];
  assign ram_waddr = {wr_ptr, wr_waddr};
  assign ram_raddr = {rd_ptr, rd.raddr};

  assign wr.free   = (slot_state[wr_ptr] == BUF_UNUSED);

  assign rd.loaded = (slot_state[rd_ptr] == BUF_LOADED);
  assign rd.words  = slot_words[rd_ptr];
  assign rd.lwdv   = slot_lwdv[rd_ptr];
  assign rd.rdata  = rdata_q;

  // ----------------------------------------
  // Word RAM
  // ----------------------------------------

  always_ff @(posedge i_clk) begin
    if (wr.we) begin
      ram[ram_waddr] <= wr.wdata;
    end
    if (rd.re) begin
      rdata_q <= ram[ram_raddr];
    end
  end

  // ----------------------------------------
  // Slot tables and pointers
  // ----------------------------------------

  // Write and read strobes always address different slots, so the
  // state updates below never collide
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < NUM_BUFFERS; i++) begin
        slot_state[i] <= BUF_UNUSED;
        slot_words[i] <= '0;
        slot_lwdv[i]  <= '0;
      end
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      wr_count <= '0;
    end else begin
      // Producer side
      if (wr.start) begin
        slot_state[wr_ptr] <= BUF_WRITING;
        slot_lwdv[wr_ptr]  <= wr.lwdv;
        wr_count           <= '0;
      end else if (wr.we) begin
        wr_count <= wr_count + 1'b1;
      end

      if (wr.commit) begin
        slot_state[wr_ptr] <= BUF_LOADED;
        slot_words[wr_ptr] <= wr_count;
        wr_ptr             <= wr_ptr + 1'b1;
      end

      // Consumer side
      if (rd.take) begin
        slot_state[rd_ptr] <= BUF_READING;
      end

      if (rd.release_slot) begin
        slot_state[rd_ptr] <= BUF_UNUSED;
        rd_ptr             <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// File: tb_nts_extractor.sv
// Testbench for the packet extractor with engine FIFO and MAC models
`timescale 1ns/1ps

module tb_nts_extractor;

  localparam int MAX_PKTS    = 16;
  localparam int MAX_WORDS   = MAX_PKTS * nts_extractor_pkg::BUF_WORDS;
  localparam int WAIT_CYCLES = 1000;

  logic                                 i_clk;
  logic                                 i_areset;
  logic                                 i_engine_packet_available;
  logic                                 i_engine_fifo_empty;
  logic [nts_extractor_pkg::DATA_W-1:0] i_engine_fifo_rd_data;
  logic [3:0]                           i_engine_bytes_last_word;
  logic                                 i_mac_tx_ack;
  logic                                 o_engine_packet_read;
  logic                                 o_engine_fifo_rd_en;
  logic                                 o_mac_tx_start;
  logic [7:0]                           o_mac_tx_data_valid;
  logic [nts_extractor_pkg::DATA_W-1:0] o_mac_tx_data;

  // Packets from the test file
  logic [nts_extractor_pkg::DATA_W-1:0] words [MAX_WORDS];
  int                                   pkt_first [MAX_PKTS];
  int                                   pkt_nwords [MAX_PKTS];
  int                                   pkt_lwdv [MAX_PKTS];
  int                                   pkt_delay [MAX_PKTS];
  logic [7:0]                           exp_mask [MAX_PKTS];
  logic [nts_extractor_pkg::DATA_W-1:0] exp_data [MAX_PKTS];
  int                                   num_pkts;
  int                                   num_words;

  // Model state
  logic [nts_extractor_pkg::DATA_W-1:0] fifo_q [$];
  logic        load_req;
  int          load_idx;
  int          pr_count;
  int          start_count;
  int          done_count;
  int          rx_idx;
  int          beat;
  logic        in_pkt;
  logic        ack_pending;
  int          ack_wait;
  logic [31:0] rng;

  nts_extractor dut_i (.*);

  always #5 i_clk = ~i_clk;

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic read_tests();
    int    fd;
    int    code;
    int    n;
    int    l;
    int    d;
    string tag;
    string rest;
    fd = $fopen("nts_extractor_tests.txt", "r");
    if (fd == 0) begin
      stop_on_failure("Could not open the test file nts_extractor_tests.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%d %d %d", n, l, d);
        pkt_first[num_pkts]  = num_words;
        pkt_nwords[num_pkts] = n;
        pkt_lwdv[num_pkts]   = l;
        pkt_delay[num_pkts]  = d;
        num_pkts++;
      end else if (tag == "W") begin
        code = $fscanf(fd, "%h", words[num_words]);
        num_words++;
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %h", exp_mask[num_pkts-1], exp_data[num_pkts-1]);
      end else begin
        stop_on_failure("Unknown line tag in the test file");
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // Engine FIFO model
  // ----------------------------------------

  always @(posedge i_clk) begin
    if (o_engine_fifo_rd_en) begin
      // The next packet may only be read once enough transmissions have ended
      assert (done_count >= pr_count + 1 - nts_extractor_pkg::NUM_BUFFERS)
        else stop_on_failure($sformatf("[ERROR] %0t: FIFO read of packet %0d with %0d sent",
                                       $time, pr_count, done_count));
      void'(fifo_q.pop_front());
    end
    if (load_req) begin
      for (int i = 0; i < pkt_nwords[load_idx]; i++) begin
        fifo_q.push_back(words[pkt_first[load_idx] + i]);
      end
      i_engine_bytes_last_word  <= 4'(pkt_lwdv[load_idx]);
      i_engine_packet_available <= 1'b1;
    end
    if (o_engine_packet_read) begin
      assert (fifo_q.size() == 0 && i_engine_packet_available)
        else stop_on_failure($sformatf("[ERROR] %0t: packet read %0d with %0d words left",
                                       $time, pr_count, fifo_q.size()));
      if (pkt_delay[0] >= 100 && pr_count < nts_extractor_pkg::NUM_BUFFERS) begin
        assert (done_count == 0)
          else stop_on_failure($sformatf("[ERROR] %0t: packet %0d stored after a send",
                                         $time, pr_count));
      end
      i_engine_packet_available <= 1'b0;
      pr_count <= pr_count + 1;
    end
    i_engine_fifo_empty   <= (fifo_q.size() == 0);
    i_engine_fifo_rd_data <= (fifo_q.size() == 0) ? 64'd0 : fifo_q[0];
  end

  // ----------------------------------------
  // MAC model and beat monitor
  // ----------------------------------------

  always @(posedge i_clk) begin
    i_mac_tx_ack <= 1'b0;
    if (o_mac_tx_start) begin
      assert (start_count < num_pkts)
        else stop_on_failure("MAC start pulse with no packet left to send");
      ack_wait    <= pkt_delay[start_count];
      ack_pending <= 1'b1;
      start_count <= start_count + 1;
    end else if (ack_pending) begin
      if (ack_wait == 0) begin
        i_mac_tx_ack <= 1'b1;
        ack_pending  <= 1'b0;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  always @(posedge i_clk) begin
    if (!i_areset && o_mac_tx_data_valid != 8'd0) begin
      assert (rx_idx < num_pkts)
        else stop_on_failure("Data beat after every packet was received");
      if (beat == 0) begin
        assert (start_count == rx_idx + 1)
          else stop_on_failure($sformatf("[ERROR] %0t: packet %0d data with %0d starts",
                                         $time, rx_idx, start_count));
      end
      if (beat < pkt_nwords[rx_idx] - 1) begin
        assert (o_mac_tx_data_valid == 8'hff &&
                o_mac_tx_data == words[pkt_first[rx_idx] + beat])
          else stop_on_failure($sformatf("[ERROR] %0t: packet %0d beat %0d got %h/%h",
                                         $time, rx_idx, beat, o_mac_tx_data_valid,
                                         o_mac_tx_data));
        beat   <= beat + 1;
        in_pkt <= 1'b1;
      end else begin
        assert (o_mac_tx_data_valid == exp_mask[rx_idx] && o_mac_tx_data == exp_data[rx_idx])
          else stop_on_failure($sformatf("[ERROR] %0t: packet %0d last beat %h/%h, want %h/%h",
                                         $time, rx_idx, o_mac_tx_data_valid, o_mac_tx_data,
                                         exp_mask[rx_idx], exp_data[rx_idx]));
        beat       <= 0;
        in_pkt     <= 1'b0;
        rx_idx     <= rx_idx + 1;
        done_count <= done_count + 1;
      end
    end else if (!i_areset) begin
      assert (o_mac_tx_data == 64'd0 && !in_pkt)
        else stop_on_failure($sformatf("[ERROR] %0t: idle beat data %h or gap in packet %0d",
                                       $time, o_mac_tx_data, rx_idx));
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    int cycles;
    i_clk = 1'b0;
    i_areset = 1'b1;
    i_engine_packet_available = 1'b0;
    i_engine_fifo_empty = 1'b1;
    i_engine_fifo_rd_data = '0;
    i_engine_bytes_last_word = '0;
    i_mac_tx_ack = 1'b0;
    load_req = 1'b0;
    load_idx = 0;
    pr_count = 0;
    start_count = 0;
    done_count = 0;
    rx_idx = 0;
    beat = 0;
    in_pkt = 1'b0;
    ack_pending = 1'b0;
    ack_wait = 0;
    num_pkts = 0;
    num_words = 0;
    rng = 32'h8567_7779;
    read_tests();

    repeat (2) @(posedge i_clk);
    i_areset <= 1'b0;

    // Outputs stay quiet before any packet is offered
    repeat (4) begin
      @(posedge i_clk);
      assert (!o_mac_tx_start && o_mac_tx_data_valid == 8'd0 && o_mac_tx_data == 64'd0 &&
              !o_engine_fifo_rd_en && !o_engine_packet_read)
        else stop_on_failure($sformatf("[ERROR] %0t: output active after reset", $time));
    end

    for (int p = 0; p < num_pkts; p++) begin
      rng = lcg_next(rng);
      repeat (rng[18:16]) @(posedge i_clk);
      load_idx <= p;
      load_req <= 1'b1;
      @(posedge i_clk);
      load_req <= 1'b0;
      cycles = 0;
      while (pr_count <= p) begin
        @(posedge i_clk);
        cycles++;
        if (cycles > WAIT_CYCLES) begin
          stop_on_failure($sformatf("Timed out waiting for packet %0d to be read", p));
        end
      end
    end

    cycles = 0;
    while (rx_idx < num_pkts) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > WAIT_CYCLES) begin
        stop_on_failure("Timed out waiting for the MAC to receive every packet");
      end
    end
    @(posedge i_clk);

    assert (start_count == num_pkts && pr_count == num_pkts)
      else stop_on_failure($sformatf("[ERROR] %0t: %0d starts, %0d reads for %0d packets",
                                     $time, start_count, pr_count, num_pkts));
    $display("NO ERRORS");
    $finish;
  end

endmodule
